// ==== logic/rv_settings.svh ====
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// data and address width
`define RV_XLEN 32

// RV32E register file, so only 4 index bits are used
`define RV_NUM_REGS 16

// first fetch address after reset
`define RV_RESET_PC 32'h3000_0000

// major opcodes, inst[6:0]
`define RV_OPC_OP    7'b0110011
`define RV_OPC_OPIMM 7'b0010011
`define RV_OPC_LUI   7'b0110111
`define RV_OPC_JALR  7'b1100111
`define RV_OPC_LOAD  7'b0000011
`define RV_OPC_STORE 7'b0100011

`endif

// ==== logic/rv_pkg.sv ====
`include "rv_settings.svh"

package rv_pkg;

  // ================================================
  // wishbone classic
  // ================================================
  typedef struct packed {
    logic                   cyc;
    logic                   stb;
    logic                   we;
    logic [`RV_XLEN-1:0]    adr;
    logic [`RV_XLEN-1:0]    dat_w;
    logic [`RV_XLEN/8-1:0]  sel;
  } wb_req_t;

  typedef struct packed {
    logic                ack;
    logic [`RV_XLEN-1:0] dat_r;
  } wb_rsp_t;

  // ================================================
  // decoded instruction
  // ================================================
  typedef enum logic [2:0] {
    op_add,
    op_addi,
    op_lui,
    op_jalr,
    op_lw,
    op_sw,
    op_nop
  } op_e;

  typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_idx_t;

  typedef struct packed {
    op_e                 op;
    reg_idx_t            rd;
    reg_idx_t            rs1;
    reg_idx_t            rs2;
    logic [`RV_XLEN-1:0] imm;
  } dec_t;

endpackage

// ==== logic/rv_fetch.sv ====
`timescale 1ns/1ns
`include "rv_settings.svh"

module rv_fetch
  import rv_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                retire,
  input  logic [`RV_XLEN-1:0] next_pc,
  output wb_req_t             ibus_req,
  input  wb_rsp_t             ibus_rsp,
  output logic [31:0]         inst,
  output logic                inst_valid,
  output logic [`RV_XLEN-1:0] pc
);

  typedef enum logic [1:0] {
    fetch_idle,
    fetch_req,
    fetch_hold
  } fetch_state_e;

  fetch_state_e state;

  // ================================================
  // pc and fetch FSM
  // ================================================
  // idle is only left once, right after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= fetch_idle;
      pc    <= `RV_RESET_PC;
    end else begin
      case (state)
        fetch_idle: state <= fetch_req;
        fetch_req: begin
          if (ibus_rsp.ack) state <= fetch_hold;
        end
        fetch_hold: begin
          // instruction done, go for the next one
          if (retire) begin
            state <= fetch_req;
            pc    <= next_pc;
          end
        end
        default: state <= fetch_idle;
      endcase
    end
  end

  // instruction word, held until retire
  always_ff @(posedge clk) begin
    if (state == fetch_req && ibus_rsp.ack) inst <= ibus_rsp.dat_r;
  end

  assign inst_valid = (state == fetch_hold);

  // read only bus, full word
  assign ibus_req.cyc   = (state == fetch_req);
  assign ibus_req.stb   = (state == fetch_req);
  assign ibus_req.we    = 1'b0;
  assign ibus_req.adr   = pc;
  assign ibus_req.dat_w = '0;
  assign ibus_req.sel   = '1;

endmodule

// ==== logic/rv_decode.sv ====
`timescale 1ns/1ns
`include "rv_settings.svh"

module rv_decode
  import rv_pkg::*;
(
  input  logic [31:0] inst,
  output dec_t        dec
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_u;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];

  // immediate formats
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {inst[31:12], 12'h000};

  // ================================================
  // operation and operands
  // ================================================
  always_comb begin
    // top index bit dropped, 16 registers only
    dec.rd  = inst[10:7];
    dec.rs1 = inst[18:15];
    dec.rs2 = inst[23:20];

    case (opcode)
      `RV_OPC_OP:    dec.op = (funct3 == 3'd0) ? op_add : op_nop;
      `RV_OPC_OPIMM: dec.op = (funct3 == 3'd0) ? op_addi : op_nop;
      `RV_OPC_LUI:   dec.op = op_lui;
      `RV_OPC_JALR:  dec.op = op_jalr;
      `RV_OPC_LOAD:  dec.op = (funct3 == 3'd2) ? op_lw : op_nop;
      `RV_OPC_STORE: dec.op = (funct3 == 3'd2) ? op_sw : op_nop;
      default:       dec.op = op_nop;
    endcase

    // pick the format this operation needs
    case (dec.op)
      op_addi,
      op_lw,
      op_jalr: dec.imm = imm_i;
      op_sw:   dec.imm = imm_s;
      op_lui:  dec.imm = imm_u;
      default: dec.imm = '0;
    endcase
  end

endmodule

// ==== logic/rv_regfile.sv ====
`timescale 1ns/1ns
`include "rv_settings.svh"

module rv_regfile
  import rv_pkg::*;
(
  input  logic                clk,
  input  reg_idx_t            rs1,
  input  reg_idx_t            rs2,
  output logic [`RV_XLEN-1:0] rs1_data,
  output logic [`RV_XLEN-1:0] rs2_data,
  input  logic                we,
  input  reg_idx_t            rd,
  input  logic [`RV_XLEN-1:0] wdata
);

  logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

  always_ff @(posedge clk) begin
    if (we) regs[rd] <= wdata;
  end

  // x0 reads as zero, writes to it are harmless
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== logic/rv_execute.sv ====
`timescale 1ns/1ns
`include "rv_settings.svh"

module rv_execute
  import rv_pkg::*;
(
  input  dec_t                dec,
  input  logic [`RV_XLEN-1:0] pc,
  input  logic [`RV_XLEN-1:0] rs1_data,
  input  logic [`RV_XLEN-1:0] rs2_data,
  input  logic [`RV_XLEN-1:0] load_data,
  input  logic                retire,
  output logic [`RV_XLEN-1:0] mem_addr,
  output logic [`RV_XLEN-1:0] next_pc,
  output logic                rd_we,
  output logic [`RV_XLEN-1:0] rd_wdata
);

  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] op_b;
  logic [`RV_XLEN-1:0] sum;
  logic [`RV_XLEN-1:0] pc_plus4;

  // ================================================
  // operand select and adder
  // ================================================
  always_comb begin
    op_a = rs1_data;
    op_b = dec.imm;
    if (dec.op == op_add) op_b = rs2_data;
    // lui is 0 + upper immediate
    if (dec.op == op_lui) op_a = '0;
  end

  assign sum      = op_a + op_b;
  assign pc_plus4 = pc + `RV_XLEN'd4;
  assign mem_addr = sum;

  // jump target has bit 0 cleared
  assign next_pc = (dec.op == op_jalr) ? {sum[`RV_XLEN-1:1], 1'b0} : pc_plus4;

  // write back
  assign rd_we = retire && (dec.op != op_sw) && (dec.op != op_nop);

  always_comb begin
    case (dec.op)
      op_jalr: rd_wdata = pc_plus4;
      op_lw:   rd_wdata = load_data;
      default: rd_wdata = sum;
    endcase
  end

endmodule

// ==== logic/rv_lsu.sv ====
`timescale 1ns/1ns
`include "rv_settings.svh"

module rv_lsu
  import rv_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                inst_valid,
  input  op_e                 op,
  input  logic [`RV_XLEN-1:0] mem_addr,
  input  logic [`RV_XLEN-1:0] store_data,
  output wb_req_t             dbus_req,
  input  wb_rsp_t             dbus_rsp,
  output logic [`RV_XLEN-1:0] load_data,
  output logic                retire
);

  typedef enum logic [1:0] {
    lsu_idle,
    lsu_bus,
    lsu_done
  } lsu_state_e;

  lsu_state_e          state;
  logic                is_mem;
  logic                start;
  logic                we_q;
  logic [`RV_XLEN-1:0] adr_q;
  logic [`RV_XLEN-1:0] dat_w_q;

  assign is_mem = (op == op_lw) || (op == op_sw);
  assign start  = (state == lsu_idle) && inst_valid;

  // ================================================
  // data bus FSM
  // ================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= lsu_idle;
    end else begin
      case (state)
        lsu_idle: begin
          // non memory ops retire straight away
          if (inst_valid) state <= is_mem ? lsu_bus : lsu_done;
        end
        lsu_bus: begin
          if (dbus_rsp.ack) state <= lsu_done;
        end
        lsu_done: state <= lsu_idle;
        default:  state <= lsu_idle;
      endcase
    end
  end

  // request fields, captured once per access
  always_ff @(posedge clk) begin
    if (start && is_mem) begin
      adr_q   <= {mem_addr[`RV_XLEN-1:2], 2'b00};
      we_q    <= (op == op_sw);
      dat_w_q <= store_data;
    end
    if (state == lsu_bus && dbus_rsp.ack) load_data <= dbus_rsp.dat_r;
  end

  assign retire = (state == lsu_done);

  // word access only
  assign dbus_req.cyc   = (state == lsu_bus);
  assign dbus_req.stb   = (state == lsu_bus);
  assign dbus_req.we    = we_q;
  assign dbus_req.adr   = adr_q;
  assign dbus_req.dat_w = dat_w_q;
  assign dbus_req.sel   = '1;

endmodule

// ==== logic/rv_core.sv ====
`timescale 1ns/1ns
`include "rv_settings.svh"

module rv_core
  import rv_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  output wb_req_t ibus_req,
  input  wb_rsp_t ibus_rsp,
  output wb_req_t dbus_req,
  input  wb_rsp_t dbus_rsp
);

  logic [31:0]         inst;
  logic                inst_valid;
  logic [`RV_XLEN-1:0] pc;
  logic [`RV_XLEN-1:0] next_pc;
  logic                retire;
  dec_t                dec;
  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;
  logic [`RV_XLEN-1:0] mem_addr;
  logic                rd_we;
  logic [`RV_XLEN-1:0] rd_wdata;
  logic [`RV_XLEN-1:0] load_data;

  // ================================================
  // stages
  // ================================================
  rv_fetch fetch0 (
    .clk, .rst, .retire, .next_pc, .ibus_req, .ibus_rsp,
    .inst, .inst_valid, .pc
  );

  rv_decode decode0 (
    .inst,
    .dec
  );

  rv_regfile regfile0 (
    .clk,
    .rs1      (dec.rs1),
    .rs2      (dec.rs2),
    .rs1_data,
    .rs2_data,
    .we       (rd_we),
    .rd       (dec.rd),
    .wdata    (rd_wdata)
  );

  rv_execute execute0 (
    .dec, .pc, .rs1_data, .rs2_data, .load_data, .retire,
    .mem_addr, .next_pc, .rd_we, .rd_wdata
  );

  // store data comes straight from rs2
  rv_lsu lsu0 (
    .clk, .rst, .inst_valid,
    .op         (dec.op),
    .mem_addr,
    .store_data (rs2_data),
    .dbus_req, .dbus_rsp, .load_data, .retire
  );

endmodule

// ==== tb/wb_mem_model.sv ====
`timescale 1ns/1ns
`include "rv_settings.svh"

module wb_mem_model
  import rv_pkg::*;
#(
  parameter int WORDS = 256
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    stall,
  input  wb_req_t req,
  output wb_rsp_t rsp
);

  localparam int AW = $clog2(WORDS);

  logic [`RV_XLEN-1:0] mem [WORDS];
  logic [AW-1:0]       idx;
  logic                grant;
  logic                ack_q;
  logic [`RV_XLEN-1:0] dat_q;

  // word index, upper address bits alias
  assign idx   = req.adr[AW+1:2];
  // one wait state minimum, more while stall is high
  assign grant = !rst && req.cyc && req.stb && !ack_q && !stall;

  always_ff @(posedge clk) begin
    if (rst) ack_q <= 1'b0;
    else     ack_q <= grant;
  end

  always @(posedge clk) begin
    if (grant) begin
      for (int b = 0; b < `RV_XLEN/8; b++) begin
        if (req.we && req.sel[b]) mem[idx][8*b +: 8] <= req.dat_w[8*b +: 8];
      end
      dat_q <= mem[idx];
    end
  end

  assign rsp.ack   = ack_q;
  assign rsp.dat_r = dat_q;

endmodule

// ==== tb/rv_core_tb.sv ====
`timescale 1ns/1ns
`include "rv_settings.svh"

module rv_core_tb
  import rv_pkg::*;
();

  logic        clk;
  logic        rst;
  logic        rst_q;
  logic        istall;
  logic        dstall;
  logic        stall_en;
  logic [31:0] lfsr;
  wb_req_t     ibus_req;
  wb_rsp_t     ibus_rsp;
  wb_req_t     dbus_req;
  wb_rsp_t     dbus_rsp;
  logic [31:0] shadow [16];
  logic [31:0] prog_pc;
  logic [31:0] loop_pc;
  logic [31:0] fetch_q [$];
  logic [31:0] store_adr_q [$];
  logic [31:0] store_dat_q [$];
  int          errors;
  int          tests_run;
  int          tests_failed;

  rv_core dut0 (.clk, .rst, .ibus_req, .ibus_rsp, .dbus_req, .dbus_rsp);

  wb_mem_model #(.WORDS(256)) imem0 (
    .clk, .rst, .stall(istall), .req(ibus_req), .rsp(ibus_rsp)
  );
  wb_mem_model #(.WORDS(256)) dmem0 (
    .clk, .rst, .stall(dstall), .req(dbus_req), .rsp(dbus_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) rst_q <= rst;

  // ================================================
  // helpers
  // ================================================
  // fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] sext12(logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  function automatic logic [31:0] fill_word(logic [31:0] word_idx);
    return (word_idx * 32'h9e37_79b9) ^ 32'h5a5a_0000;
  endfunction

  function automatic logic [31:0] enc_i(logic [6:0] opc, logic [3:0] rd, logic [2:0] f3,
                                        logic [3:0] rs1, logic [11:0] imm);
    return {imm, 1'b0, rs1, f3, 1'b0, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(logic [3:0] rs2, logic [3:0] rs1, logic [11:0] imm);
    return {imm[11:5], 1'b0, rs2, 1'b0, rs1, 3'd2, imm[4:0], `RV_OPC_STORE};
  endfunction

  task automatic report_mismatch(string msg);
    $display("Mismatch at %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic give_up(string what);
    $display("Timeout: %s", what);
    $display("Done: errors found");
    $finish;
  endtask

  task automatic finish_test(string name, int start_errors);
    tests_run++;
    if (errors != start_errors) tests_failed++;
    $display("test %0d %s: %0d errors", tests_run, name, errors - start_errors);
  endtask

  // ================================================
  // program builder with a register model
  // ================================================
  task automatic put_inst(logic [31:0] word);
    imem0.mem[prog_pc[9:2]] = word;
    fetch_q.push_back(prog_pc);
    prog_pc = prog_pc + 32'd4;
  endtask

  task automatic set_reg(logic [3:0] rd, logic [31:0] val);
    if (rd != 4'd0) shadow[rd] = val;
  endtask

  task automatic emit_lui(logic [3:0] rd, logic [19:0] imm);
    set_reg(rd, {imm, 12'h000});
    put_inst({imm, 1'b0, rd, `RV_OPC_LUI});
  endtask

  task automatic emit_addi(logic [3:0] rd, logic [3:0] rs1, logic [11:0] imm);
    set_reg(rd, shadow[rs1] + sext12(imm));
    put_inst(enc_i(`RV_OPC_OPIMM, rd, 3'd0, rs1, imm));
  endtask

  task automatic emit_add(logic [3:0] rd, logic [3:0] rs1, logic [3:0] rs2);
    set_reg(rd, shadow[rs1] + shadow[rs2]);
    put_inst({8'd0, rs2, 1'b0, rs1, 3'd0, 1'b0, rd, `RV_OPC_OP});
  endtask

  task automatic emit_lw(logic [3:0] rd, logic [3:0] rs1, logic [11:0] imm);
    logic [31:0] adr;
    adr = shadow[rs1] + sext12(imm);
    set_reg(rd, fill_word({24'd0, adr[9:2]}));
    put_inst(enc_i(`RV_OPC_LOAD, rd, 3'd2, rs1, imm));
  endtask

  task automatic emit_sw(logic [3:0] rs2, logic [3:0] rs1, logic [11:0] imm);
    logic [31:0] adr;
    adr = shadow[rs1] + sext12(imm);
    store_adr_q.push_back({adr[31:2], 2'b00});
    store_dat_q.push_back(shadow[rs2]);
    put_inst(enc_s(rs2, rs1, imm));
  endtask

  task automatic emit_jalr(logic [3:0] rd, logic [3:0] rs1, logic [11:0] imm);
    logic [31:0] target;
    target = shadow[rs1] + sext12(imm);
    set_reg(rd, prog_pc + 32'd4);
    put_inst(enc_i(`RV_OPC_JALR, rd, 3'd0, rs1, imm));
    prog_pc = {target[31:1], 1'b0};
  endtask

  task automatic load_program();
    logic [31:0] off;
    fetch_q.delete();
    store_adr_q.delete();
    store_dat_q.delete();
    foreach (shadow[i]) shadow[i] = '0;
    prog_pc = `RV_RESET_PC;
    emit_lui(4'd1, 20'h30000);
    emit_lui(4'd2, 20'h12345);
    emit_addi(4'd3, 4'd2, 12'h678);
    emit_addi(4'd4, 4'd3, 12'hfff);
    emit_addi(4'd5, 4'd0, 12'h800);
    emit_add(4'd6, 4'd4, 4'd5);
    emit_add(4'd7, 4'd6, 4'd6);
    for (int r = 2; r <= 7; r++) emit_sw(r[3:0], 4'd0, 12'h100 + 12'(4 * (r - 2)));
    // unknown opcode runs as a nop
    put_inst(32'h0000_007f);
    emit_lw(4'd8, 4'd0, 12'h200);
    emit_sw(4'd8, 4'd0, 12'h120);
    // low address bits dropped on both accesses
    emit_lw(4'd9, 4'd0, 12'h206);
    emit_sw(4'd9, 4'd0, 12'h125);
    emit_addi(4'd0, 4'd0, 12'h055);
    emit_sw(4'd0, 4'd0, 12'h130);
    // skipped word holds a store that must never show up
    imem0.mem[prog_pc[9:2] + 8'd1] = enc_s(4'd1, 4'd0, 12'h138);
    off = prog_pc + 32'd9 - shadow[1];
    emit_jalr(4'd11, 4'd1, off[11:0]);
    emit_sw(4'd11, 4'd0, 12'h134);
    loop_pc = prog_pc;
    off = loop_pc - shadow[1];
    emit_jalr(4'd0, 4'd1, off[11:0]);
  endtask

  task automatic wait_for_program(string what);
    bit done;
    done = 1'b0;
    for (int i = 0; i < 4000 && !done; i++) begin
      @(negedge clk);
      done = (fetch_q.size() == 0) && (store_adr_q.size() == 0);
    end
    if (!done) give_up({what, " never reached its final loop"});
  endtask

  // ================================================
  // stalls, monitors and assertions
  // ================================================
  always @(negedge clk) begin
    if (stall_en) begin
      lfsr   = lfsr_step(lfsr);
      istall = lfsr[0];
      lfsr   = lfsr_step(lfsr);
      dstall = lfsr[0];
    end else begin
      istall = 1'b0;
      dstall = 1'b0;
    end
  end

  always @(posedge clk) begin : fetch_monitor
    logic [31:0] want;
    if (!rst && ibus_req.stb && ibus_rsp.ack) begin
      want = (fetch_q.size() > 0) ? fetch_q.pop_front() : loop_pc;
      assert (ibus_req.adr == want)
        else report_mismatch($sformatf("fetch at %h, expected %h", ibus_req.adr, want));
    end
  end

  always @(posedge clk) begin : store_monitor
    logic [31:0] want_adr;
    logic [31:0] want_dat;
    if (!rst && dbus_req.stb && dbus_rsp.ack && dbus_req.we) begin
      assert (store_adr_q.size() > 0)
        else report_mismatch($sformatf("unexpected store to %h", dbus_req.adr));
      if (store_adr_q.size() > 0) begin
        want_adr = store_adr_q.pop_front();
        want_dat = store_dat_q.pop_front();
        assert (dbus_req.adr == want_adr && dbus_req.dat_w == want_dat)
          else report_mismatch($sformatf("store %h to %h, expected %h to %h",
                                         dbus_req.dat_w, dbus_req.adr, want_dat, want_adr));
      end
    end
  end

  a_reset_idle: assert property (@(posedge clk) rst_q |-> !ibus_req.cyc && !dbus_req.cyc)
    else report_mismatch("bus cycle active during or right after reset");

  a_ibus_hold: assert property (@(posedge clk) disable iff (rst)
    ibus_req.stb && !ibus_rsp.ack |=> ibus_req.stb && $stable(ibus_req))
    else report_mismatch("ibus request changed before ack");

  a_dbus_hold: assert property (@(posedge clk) disable iff (rst)
    dbus_req.stb && !dbus_rsp.ack |=> dbus_req.stb && $stable(dbus_req))
    else report_mismatch("dbus request changed before ack");

  a_ibus_read: assert property (@(posedge clk)
    ibus_req.stb |-> !ibus_req.we && ibus_req.sel == 4'hf)
    else report_mismatch("ibus request is not a full word read");

  a_dbus_word: assert property (@(posedge clk)
    dbus_req.stb |-> dbus_req.sel == 4'hf && dbus_req.adr[1:0] == 2'b00)
    else report_mismatch("dbus access is not an aligned full word");

  // ================================================
  // test sequence
  // ================================================
  initial begin : main
    int start_errors;
    bit found;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    rst          = 1'b1;
    rst_q        = 1'b0;
    stall_en     = 1'b0;
    istall       = 1'b0;
    dstall       = 1'b0;
    lfsr         = 32'h2bdf;
    for (int i = 0; i < 256; i++) begin
      imem0.mem[i] = fill_word(i);
      dmem0.mem[i] = fill_word(i);
    end
    load_program();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    start_errors = errors;
    found = 1'b0;
    for (int i = 0; i < 20 && !found; i++) begin
      @(negedge clk);
      found = ibus_req.stb;
    end
    if (!found) give_up("the first instruction fetch never started");
    assert (ibus_req.adr == `RV_RESET_PC)
      else report_mismatch($sformatf("first fetch at %h", ibus_req.adr));
    finish_test("reset and first fetch", start_errors);

    start_errors = errors;
    wait_for_program("program without stalls");
    finish_test("program without stalls", start_errors);

    // second run from reset with random wait states
    start_errors = errors;
    @(negedge clk);
    rst = 1'b1;
    @(posedge clk);
    stall_en = 1'b1;
    @(negedge clk);
    load_program();
    @(negedge clk);
    rst = 1'b0;
    wait_for_program("program with random stalls");
    finish_test("program with random stalls", start_errors);

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) $display("Done: no errors");
    else $display("Done: errors found");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+logic
logic/rv_pkg.sv
logic/rv_fetch.sv
logic/rv_decode.sv
logic/rv_regfile.sv
logic/rv_execute.sv
logic/rv_lsu.sv
logic/rv_core.sv
tb/wb_mem_model.sv
tb/rv_core_tb.sv
